/* run.sh */
#!/bin/sh
# Build and run the instruction fetch testbench with Verilator

LOG=sim.log

verilator --binary --timing -f tb.f --top-module tb_ifetch -o sim_ifetch
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_ifetch > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Outcome comes from the log
if grep -q "Regression failed" "$LOG"; then
    exit 1
fi
exit 0

/* tb.f */
verilog/ifetch_pkg.sv
verilog/fetch_addr_gen.sv
verilog/instr_align.sv
verilog/fetch_out_stage.sv
verilog/ifetch_top.sv
tb/tb_clock.sv
tb/tb_ifetch.sv

/* tb/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock (
    output logic clk_o,
    output logic rst_o
);

    // Rising edges seen while reset is held
    int unsigned rst_edges = 0;

    // 10 ns period
    initial begin
        clk_o = 1'b0;
        forever begin
            #5 clk_o = ~clk_o;
        end
    end

    always @(posedge clk_o) begin
        if (rst_edges < 3) begin
            rst_edges <= rst_edges + 1;
        end
    end

    // Active low, released right after the third rising edge
    assign rst_o = (rst_edges >= 3);

endmodule

/* tb/tb_ifetch.sv */
`timescale 1ns/100ps

module tb_ifetch
    import ifetch_pkg::*;
();

    localparam int MEM_WORDS    = 256;
    localparam int SEQ_CYCLES   = 400;
    localparam int TOTAL_CYCLES = 3000;
    localparam int IDLE_LIMIT   = 64;
    localparam int MIN_XFERS    = 400;

    logic   clk;
    logic   rst;
    logic   branch;
    pc_t    branch_target;
    waddr_t mem_addr;
    word_t  mem_data;
    logic   mem_valid;
    logic   out_valid;
    logic   out_ready;
    instr_t out_instr;
    logic   out_long;
    pc_t    out_pc;

    word_t       mem [0:MEM_WORDS-1];
    logic [31:0] seed;
    pc_t         ref_pc;
    int          value_errors;
    int          other_errors;

    tb_clock u_clock (
        .clk_o (clk),
        .rst_o (rst)
    );

    ifetch_top u_dut (
        .clk_i           (clk),
        .rst_i           (rst),
        .branch_i        (branch),
        .branch_target_i (branch_target),
        .mem_addr_o      (mem_addr),
        .mem_data_i      (mem_data),
        .mem_valid_i     (mem_valid),
        .out_valid_o     (out_valid),
        .out_ready_i     (out_ready),
        .out_instr_o     (out_instr),
        .out_long_o      (out_long),
        .out_pc_o        (out_pc)
    );

    // Memory answers in the same cycle, address wraps at the array size
    assign mem_data = mem[mem_addr[7:0]];

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Upper bits of the generator are the better mixed ones
    task automatic draw_rand(output logic [15:0] r);
        seed = lcg_step(seed);
        r = seed[31:16];
    endtask

    function automatic half_t image_half(input pc_t hpc);
        word_t w;
        w = mem[hpc[8:1]];
        return hpc[0] ? w[31:16] : w[15:0];
    endfunction

    // Reference fetch, counter kept in halfword units
    task automatic model_next(output instr_t instr, output logic is_long, output pc_t pc);
        half_t lo;
        lo = image_half(ref_pc);
        pc = ref_pc;
        if (&lo[1:0]) begin
            instr   = {image_half(ref_pc + pc_t'(1)), lo};
            is_long = 1'b1;
            ref_pc  = ref_pc + pc_t'(2);
        end else begin
            instr   = {16'h0000, lo};
            is_long = 1'b0;
            ref_pc  = ref_pc + pc_t'(1);
        end
    endtask

    task automatic check_instr(input string name, input instr_t exp, input instr_t act);
        if (act !== exp) begin
            $display("error %s: expected %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_pc(input string name, input pc_t exp, input pc_t act);
        if (act !== exp) begin
            $display("error %s: expected %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error %s: expected %b, actual %b", name, exp, act);
            value_errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and checking
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        instr_t      exp_instr;
        logic        exp_long;
        pc_t         exp_pc;
        instr_t      held_instr;
        logic        held_long;
        pc_t         held_pc;
        logic        holding;
        logic        after_branch;
        logic        first;
        logic        abort;
        logic [15:0] rnd;
        logic [15:0] rnd_hi;
        string       tname;
        int          i;
        int          n;
        int          cycle;
        int          idle;
        int          xfers;
        int          branches;

        seed          = 32'he481_2a57;
        branch        = 1'b0;
        branch_target = '0;
        mem_valid     = 1'b1;
        out_ready     = 1'b1;
        value_errors  = 0;
        other_errors  = 0;
        ref_pc        = '0;
        abort         = 1'b0;

        for (i = 0; i < MEM_WORDS; i++) begin
            draw_rand(rnd_hi);
            draw_rand(rnd);
            mem[i] = {rnd_hi, rnd};
        end

        // Synchronous reset acts from the first rising edge on
        @(posedge clk);

        // Output stays empty through reset and the first cycle after it
        n = 0;
        do begin
            @(negedge clk);
            check_flag("reset_valid", 1'b0, out_valid);
            n++;
        end while (rst !== 1'b1 && n < 20);
        if (rst !== 1'b1) begin
            $display("Reset was never released within 20 cycles");
            other_errors++;
            abort = 1'b1;
        end

        cycle        = 0;
        idle         = 0;
        xfers        = 0;
        branches     = 0;
        holding      = 1'b0;
        after_branch = 1'b0;
        first        = 1'b1;

        while (!abort && cycle < TOTAL_CYCLES) begin
            // Stalled outputs must not move
            if (holding) begin
                check_flag("hold_valid", 1'b1, out_valid);
                check_instr("hold_instr", held_instr, out_instr);
                check_flag("hold_long", held_long, out_long);
                check_pc("hold_pc", held_pc, out_pc);
            end

            draw_rand(rnd);
            mem_valid = (rnd[1:0] != 2'b00);
            draw_rand(rnd);
            out_ready = ((rnd % 16'd3) != 16'd0);
            draw_rand(rnd);
            branch = (cycle >= SEQ_CYCLES) && (rnd[4:0] == 5'd0);
            draw_rand(rnd);
            branch_target = pc_t'(rnd[8:0]);

            if (out_valid && out_ready) begin
                if (first) begin
                    tname = "reset_first";
                end else if (after_branch) begin
                    tname = "branch_target";
                end else if (cycle < SEQ_CYCLES) begin
                    tname = "sequential";
                end else begin
                    tname = "random_stream";
                end
                model_next(exp_instr, exp_long, exp_pc);
                check_instr({tname, "_instr"}, exp_instr, out_instr);
                check_flag({tname, "_long"}, exp_long, out_long);
                check_pc({tname, "_pc"}, exp_pc, out_pc);
                xfers++;
                idle         = 0;
                first        = 1'b0;
                after_branch = 1'b0;
            end else begin
                idle++;
            end

            // Redirect takes effect after a transfer on the same edge
            if (branch) begin
                ref_pc       = branch_target;
                after_branch = 1'b1;
                idle         = 0;
                branches++;
            end

            holding    = out_valid && !out_ready && !branch;
            held_instr = out_instr;
            held_long  = out_long;
            held_pc    = out_pc;

            if (idle > IDLE_LIMIT) begin
                if (after_branch) begin
                    $display("No instruction arrived within %0d cycles after a branch to %h",
                             IDLE_LIMIT, ref_pc);
                end else begin
                    $display("Instruction stream stalled for %0d cycles", IDLE_LIMIT);
                end
                other_errors++;
                abort = 1'b1;
            end

            cycle++;
            @(negedge clk);
        end

        if (!abort && xfers < MIN_XFERS) begin
            $display("Only %0d instructions transferred, at least %0d were expected",
                     xfers, MIN_XFERS);
            other_errors++;
        end

        $display("Checks done: %0d transfers, %0d branches, %0d value errors, %0d other errors",
                 xfers, branches, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* verilog/fetch_addr_gen.sv */
`timescale 1ns/100ps

module fetch_addr_gen
    import ifetch_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_i,

    // Redirect from execute
    input  logic   branch_i,
    input  waddr_t branch_waddr_i,

    // Word consumed by the aligner
    input  logic   advance_i,

    // Registered address to instruction memory
    output waddr_t fetch_waddr_o
);

    ////////////////////////////////////////////////////////////////////////////
    // Fetch pointer
    ////////////////////////////////////////////////////////////////////////////

    waddr_t fetch_ptr_q;
    waddr_t fetch_ptr_d;
    waddr_t fetch_ptr_inc;
    logic   fetch_ptr_en;

    // Sequential successor, one word on
    assign fetch_ptr_inc = fetch_ptr_q + waddr_t'(1);

    // Pointer moves only on a redirect or a consumed word
    assign fetch_ptr_en = branch_i | advance_i;

    // Redirect wins over the sequential step
    always_comb begin
        if (branch_i) begin
            fetch_ptr_d = branch_waddr_i;
        end else begin
            fetch_ptr_d = fetch_ptr_inc;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            fetch_ptr_q <= '0;
        end else if (fetch_ptr_en) begin
            fetch_ptr_q <= fetch_ptr_d;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Memory address
    ////////////////////////////////////////////////////////////////////////////

    // Straight from the flop, so the memory sees a stable address all cycle
    assign fetch_waddr_o = fetch_ptr_q;

endmodule

/* verilog/fetch_out_stage.sv */
`timescale 1ns/100ps

module fetch_out_stage
    import ifetch_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_i,

    // Redirect
    input  logic   branch_i,
    input  pc_t    branch_target_i,

    // From the aligner
    input  logic   emit_valid_i,
    input  instr_t emit_instr_i,
    input  logic   emit_long_i,
    output logic   emit_ready_o,

    // To decode
    output logic   out_valid_o,
    input  logic   out_ready_i,
    output instr_t out_instr_o,
    output logic   out_long_o,
    output pc_t    out_pc_o
);

    // PC of the next instruction the aligner hands over
    pc_t  pc_q;
    pc_t  pc_next;
    logic emit_fire;

    // Register free now or drained at this edge
    assign emit_ready_o = ~out_valid_o | out_ready_i;
    assign emit_fire    = emit_valid_i & emit_ready_o;

    // Long steps two halfwords, short steps one
    assign pc_next = pc_q + (emit_long_i ? pc_t'(2) : pc_t'(1));

    ////////////////////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            out_valid_o <= 1'b0;
            pc_q        <= '0;
        end else if (branch_i) begin
            // Flush, any transfer at this edge still counts as old stream
            out_valid_o <= 1'b0;
            pc_q        <= branch_target_i;
        end else if (emit_fire) begin
            out_valid_o <= 1'b1;
            pc_q        <= pc_next;
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Payload
    ////////////////////////////////////////////////////////////////////////////

    // Holds while stalled since emit_ready_o is low then
    always_ff @(posedge clk_i) begin
        if (emit_fire) begin
            out_instr_o <= emit_instr_i;
            out_long_o  <= emit_long_i;
            out_pc_o    <= pc_q;
        end
    end

endmodule

/* verilog/ifetch_pkg.sv */
package ifetch_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////

    // Data word and long instruction
    localparam int XLEN   = 32;

    // One instruction parcel
    localparam int HALF_W = 16;

    // Word address drops byte bits 1:0
    localparam int WADDR_W = XLEN - 2;

    // Halfword PC drops byte bit 0
    localparam int PC_W    = XLEN - 1;

    ////////////////////////////////////////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [XLEN-1:0]    word_t;
    typedef logic [HALF_W-1:0]  half_t;

    // Short instructions live in the low half, upper half zero
    typedef logic [XLEN-1:0]    instr_t;

    // Address bits 31:2
    typedef logic [WADDR_W-1:0] waddr_t;

    // Address bits 31:1
    typedef logic [PC_W-1:0]    pc_t;

    // Aligner FSM
    // ALIGN_HALF holds the low parcel of a long instruction
    typedef enum logic {
        ALIGN_EMPTY = 1'b0,
        ALIGN_HALF  = 1'b1
    } align_state_t;

endpackage

/* verilog/ifetch_top.sv */
`timescale 1ns/100ps

module ifetch_top
    import ifetch_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_i,

    // Branch redirect
    input  logic   branch_i,
    input  pc_t    branch_target_i,

    // Instruction memory
    output waddr_t mem_addr_o,
    input  word_t  mem_data_i,
    input  logic   mem_valid_i,

    // Decode port
    output logic   out_valid_o,
    input  logic   out_ready_i,
    output instr_t out_instr_o,
    output logic   out_long_o,
    output pc_t    out_pc_o
);

    waddr_t fetch_waddr;
    waddr_t branch_waddr;
    logic   redirect_half;
    logic   advance;
    logic   emit_valid;
    logic   emit_ready;
    instr_t emit_instr;
    logic   emit_long;

    // Target split into word address and halfword select
    assign branch_waddr  = branch_target_i[PC_W-1:1];
    assign redirect_half = branch_target_i[0];

    assign mem_addr_o = fetch_waddr;

    fetch_addr_gen u_addr_gen (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .branch_i       (branch_i),
        .branch_waddr_i (branch_waddr),
        .advance_i      (advance),
        .fetch_waddr_o  (fetch_waddr)
    );

    instr_align u_align (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .branch_i        (branch_i),
        .redirect_half_i (redirect_half),
        .mem_data_i      (mem_data_i),
        .mem_valid_i     (mem_valid_i),
        .emit_ready_i    (emit_ready),
        .emit_valid_o    (emit_valid),
        .emit_instr_o    (emit_instr),
        .emit_long_o     (emit_long),
        .advance_o       (advance)
    );

    fetch_out_stage u_out_stage (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .branch_i        (branch_i),
        .branch_target_i (branch_target_i),
        .emit_valid_i    (emit_valid),
        .emit_instr_i    (emit_instr),
        .emit_long_i     (emit_long),
        .emit_ready_o    (emit_ready),
        .out_valid_o     (out_valid_o),
        .out_ready_i     (out_ready_i),
        .out_instr_o     (out_instr_o),
        .out_long_o      (out_long_o),
        .out_pc_o        (out_pc_o)
    );

endmodule

/* verilog/instr_align.sv */
`timescale 1ns/100ps

module instr_align
    import ifetch_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_i,

    // Redirect, bit 1 of the target selects the starting half
    input  logic   branch_i,
    input  logic   redirect_half_i,

    // Memory word for the current fetch address
    input  word_t  mem_data_i,
    input  logic   mem_valid_i,

    // Instruction towards the output stage
    input  logic   emit_ready_i,
    output logic   emit_valid_o,
    output instr_t emit_instr_o,
    output logic   emit_long_o,

    // Current word fully used
    output logic   advance_o
);

    ////////////////////////////////////////////////////////////////////////////
    // State
    ////////////////////////////////////////////////////////////////////////////

    align_state_t state_q;
    align_state_t state_d;

    // 0 selects the low half of the word, 1 the high half
    logic         offset_q;
    logic         offset_d;

    // Low parcel of a long instruction that crosses a word boundary
    half_t        buf_q;
    logic         buf_load;

    ////////////////////////////////////////////////////////////////////////////
    // Parcel decode
    ////////////////////////////////////////////////////////////////////////////

    half_t lo_half;
    half_t hi_half;
    logic  lo_long;
    logic  hi_long;
    logic  emit_fire;

    assign lo_half = mem_data_i[HALF_W-1:0];
    assign hi_half = mem_data_i[XLEN-1:HALF_W];

    // Both low bits set marks a 32-bit instruction
    assign lo_long = &lo_half[1:0];
    assign hi_long = &hi_half[1:0];

    // Emit handshake completes this cycle
    // Every emit is offered as soon as the word is valid
    assign emit_fire = mem_valid_i & emit_ready_i;

    ////////////////////////////////////////////////////////////////////////////
    // Next state and outputs
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d      = state_q;
        offset_d     = offset_q;
        buf_load     = 1'b0;
        emit_valid_o = 1'b0;
        emit_instr_o = '0;
        emit_long_o  = 1'b0;
        advance_o    = 1'b0;

        case (state_q)
            ALIGN_EMPTY: begin
                if (!offset_q) begin
                    // Instruction starts at the low half
                    emit_valid_o = mem_valid_i;
                    if (lo_long) begin
                        emit_instr_o = mem_data_i;
                        emit_long_o  = 1'b1;
                        advance_o    = emit_fire;
                    end else begin
                        emit_instr_o = {{(XLEN-HALF_W){1'b0}}, lo_half};
                        if (emit_fire) begin
                            offset_d = 1'b1;
                        end
                    end
                end else if (hi_long) begin
                    // Long one split across words, park the low parcel
                    if (mem_valid_i) begin
                        buf_load  = 1'b1;
                        advance_o = 1'b1;
                        state_d   = ALIGN_HALF;
                    end
                end else begin
                    emit_valid_o = mem_valid_i;
                    emit_instr_o = {{(XLEN-HALF_W){1'b0}}, hi_half};
                    if (emit_fire) begin
                        advance_o = 1'b1;
                        offset_d  = 1'b0;
                    end
                end
            end

            ALIGN_HALF: begin
                // Upper parcel comes from the low half of the new word
                emit_valid_o = mem_valid_i;
                emit_instr_o = {lo_half, buf_q};
                emit_long_o  = 1'b1;
                if (emit_fire) begin
                    state_d  = ALIGN_EMPTY;
                    offset_d = 1'b1;
                end
            end

            default: begin
                state_d = ALIGN_EMPTY;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q  <= ALIGN_EMPTY;
            offset_q <= 1'b0;
        end else if (branch_i) begin
            // Word in flight belongs to the old stream
            state_q  <= ALIGN_EMPTY;
            offset_q <= redirect_half_i;
        end else begin
            state_q  <= state_d;
            offset_q <= offset_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (buf_load) begin
            buf_q <= hi_half;
        end
    end

endmodule
